// File: files.f
+incdir+testbench
common/rv32_exec_pkg.sv
execute/arithmetic_logic_unit.sv
decode/instr_decoder.sv
design/writeback_stage.sv
design/rv32_exec_top.sv
testbench/tb_rv32_exec.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv32_exec -f files.f

status=0
output=$(./obj_dir/Vtb_rv32_exec 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
    echo "Simulation run OK"
    exit 0
fi
echo "Simulation run reported failure"
exit 1

// File: testbench/exec_ref_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Needs rv32_exec_pkg imported and a seed variable in the includer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Operand source biased toward compare and shift corners
function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
        3'd0:    pick_operand = 32'h8000_0000;          // Most negative
        3'd1:    pick_operand = 32'h7fff_ffff;          // Most positive
        3'd2:    pick_operand = 32'hffff_ffff;          // Minus one
        3'd3:    pick_operand = 32'h0000_0000;
        default: pick_operand = $random(seed);
    endcase
endfunction

// Kind 0 R-type, 1 I-type ALU, 2 shift immediate, 3 jump, 4 AUIPC, else illegal
function automatic instr_u build_instr(input int kind);
    instr_u      w;
    logic [31:0] r;
    r = $random(seed);
    w = $random(seed);                                  // Unset fields stay random
    case (kind)
        0: begin
            w.r.opcode = opc_op;
            w.r.funct7 = (r[0] && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5)) ? 7'h20 : 7'h00;
        end
        1: begin
            w.i.opcode = opc_op_imm;
            if (w.i.funct3[1:0] == 2'b01) begin
                w.i.funct3[1] = 1'b1;                   // Steer shifts to SLTIU/ANDI
            end
        end
        2: begin
            w.i.opcode = opc_op_imm;
            w.i.funct3 = r[0] ? 3'd1 : 3'd5;
            w.r.funct7 = (r[0] || !r[1]) ? 7'h00 : 7'h20; // SRAI only on funct3 5
        end
        3: begin
            w.i.opcode = r[0] ? opc_jal : opc_jalr;
            if (!r[0]) begin
                w.i.funct3 = 3'd0;
            end
        end
        4: w.u.opcode = opc_auipc;
        default: begin
            case (r[3:2])
                2'd0: begin                             // Opcode outside the slice
                    w.r.opcode = r[14:8];
                    if (r[14:8] inside {opc_op, opc_op_imm, opc_jal, opc_jalr, opc_auipc}) begin
                        w.r.opcode = 7'b0000011;        // Load
                    end
                end
                2'd1: begin
                    w.r.opcode = opc_op;
                    w.r.funct7 = r[14:8] | 7'h01;       // Never 0 or 0x20
                end
                2'd2: begin
                    w.i.opcode = opc_jalr;
                    w.i.funct3 = r[6:4] | 3'd1;
                end
                default: begin
                    w.i.opcode = opc_op_imm;
                    w.i.funct3 = r[4] ? 3'd1 : 3'd5;
                    w.r.funct7 = r[14:8] | 7'h01;       // Bad shift funct7
                end
            endcase
        end
    endcase
    return w;
endfunction

// RV32I result rules; bad set for anything outside the slice
function automatic void model_execute(input instr_u w, input logic [31:0] pc_val,
                                      input logic [31:0] a, input logic [31:0] b,
                                      output logic bad, output logic [31:0] value);
    logic [31:0] imm;
    logic [4:0]  sh;
    bad   = 1'b0;
    value = 32'd0;
    imm   = {{20{w.i.imm[11]}}, w.i.imm};
    sh    = w.r.rs2;                                    // Shamt for immediate shifts
    case (w.r.opcode)
        opc_op: begin
            case ({w.r.funct7, w.r.funct3})
                {7'h00, 3'd0}: value = a + b;
                {7'h20, 3'd0}: value = a - b;
                {7'h00, 3'd1}: value = a << b[4:0];
                {7'h00, 3'd2}: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                {7'h00, 3'd3}: value = (a < b) ? 32'd1 : 32'd0;
                {7'h00, 3'd4}: value = a ^ b;
                {7'h00, 3'd5}: value = a >> b[4:0];
                {7'h20, 3'd5}: value = $signed(a) >>> b[4:0];
                {7'h00, 3'd6}: value = a | b;
                {7'h00, 3'd7}: value = a & b;
                default:       bad   = 1'b1;
            endcase
        end
        opc_op_imm: begin
            case (w.i.funct3)
                3'd0:    value = a + imm;
                3'd1:    value = a << sh;
                3'd2:    value = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                3'd3:    value = (a < imm) ? 32'd1 : 32'd0; // Sign-extended, compared unsigned
                3'd4:    value = a ^ imm;
                3'd5: begin
                    if (w.r.funct7 == 7'h20) begin
                        value = $signed(a) >>> sh;          // SRAI sign fill
                    end else begin
                        value = a >> sh;
                    end
                end
                3'd6:    value = a | imm;
                default: value = a & imm;
            endcase
            if (w.i.funct3 == 3'd1 && w.r.funct7 != 7'h00) begin
                bad = 1'b1;
            end
            if (w.i.funct3 == 3'd5 && w.r.funct7 != 7'h00 && w.r.funct7 != 7'h20) begin
                bad = 1'b1;
            end
        end
        opc_jal:   value = pc_val + 32'd4;                  // Link address
        opc_jalr:  begin
            value = pc_val + 32'd4;
            bad   = (w.i.funct3 != 3'd0);
        end
        opc_auipc: value = pc_val + {w.u.imm, 12'b0};
        default:   bad   = 1'b1;
    endcase
    if (bad) begin
        value = 32'd0;                                      // Suppressed result
    end
endfunction

`endif

// File: testbench/tb_rv32_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random issue with idle gaps; each result expected 2 cycles after issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_rv32_exec;
    import rv32_exec_pkg::*;

    typedef struct packed {
        int          due;                               // Step where the result shows
        int          kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        we;
        logic        ill;
    } expect_t;

    localparam int num_steps   = 800;
    localparam int drain_limit = 8;

    logic        clk = 1'b0;
    logic        reset;
    logic        issue_valid;
    instr_u      instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        wb_we;
    logic        illegal_instr;
    integer      seed = 32'hee22;
    int          step;
    expect_t     pending[$];                            // In issue order

    `include "exec_ref_model.svh"

    rv32_exec_top u_rv32_exec_top (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_we         (wb_we),
        .illegal_instr (illegal_instr)
    );

    always #10 clk = ~clk;                              // 20 ns period

    function automatic string kind_name(input int kind);
        case (kind)
            0:       return "reg_reg";
            1:       return "imm_alu";
            2:       return "imm_shift";
            3:       return "jump";
            4:       return "auipc";
            default: return "illegal";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_outputs();
        expect_t item;
        string   name;
        if (pending.size() != 0 && pending[0].due == step) begin
            item = pending.pop_front();
            name = kind_name(item.kind);
            if (wb_valid !== 1'b1) begin
                fail_run({"Result of a ", name, " instruction missing 2 cycles after issue"});
            end
            check_value({name, " wb_rd"}, {27'd0, item.rd}, {27'd0, wb_rd});
            check_value({name, " wb_data"}, item.data, wb_data);
            check_value({name, " wb_we"}, {31'd0, item.we}, {31'd0, wb_we});
            check_value({name, " illegal_instr"}, {31'd0, item.ill}, {31'd0, illegal_instr});
        end else begin
            if (wb_valid !== 1'b0) begin
                fail_run("wb_valid went high with no instruction outstanding");
            end
            check_value("idle wb_we", 32'd0, {31'd0, wb_we});
            check_value("idle illegal_instr", 32'd0, {31'd0, illegal_instr});
        end
    endtask

    // Drives the next cycle and records what the model expects
    task automatic issue_next();
        expect_t     item;
        instr_u      w;
        logic        bad;
        logic [31:0] value;
        logic [31:0] r;
        r         = $random(seed);
        item.kind = $unsigned($random(seed)) % 6;
        w         = build_instr(item.kind);
        if (r[4:2] == 3'd0) begin
            w.r.rd = 5'd0;                              // Frequent x0 destination
        end
        instr       = w;
        pc          = $random(seed) & 32'hffff_fffc;
        rs1_data    = pick_operand();
        rs2_data    = pick_operand();
        issue_valid = (r[1:0] != 2'd0);                 // Roughly one idle cycle in four
        if (issue_valid) begin
            model_execute(w, pc, rs1_data, rs2_data, bad, value);
            item.due  = step + 2;
            item.rd   = w.r.rd;
            item.data = value;
            item.we   = !bad && (w.r.rd != 5'd0);
            item.ill  = bad;
            pending.push_back(item);
        end
    endtask

    initial begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        step        = 0;
        repeat (16) begin
            @(negedge clk);
            check_value("reset wb_valid", 32'd0, {31'd0, wb_valid});
            check_value("reset wb_we", 32'd0, {31'd0, wb_we});
            check_value("reset illegal_instr", 32'd0, {31'd0, illegal_instr});
        end
        reset = 1'b0;
        repeat (num_steps) begin
            @(negedge clk);
            step = step + 1;
            check_outputs();
            issue_next();
        end
        issue_valid = 1'b0;
        for (int n = 0; n < drain_limit && pending.size() != 0; n++) begin
            @(negedge clk);
            step = step + 1;
            check_outputs();
        end
        if (pending.size() != 0) begin
            fail_run("Drain timed out with results still outstanding");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: design/rv32_exec_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed 2-cycle latency, no back-pressure; issue may be continuous
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32_exec_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               issue_valid,
    input  rv32_exec_pkg::instr_u              instr,
    input  logic [rv32_exec_pkg::xlen-1:0]     pc,
    input  logic [rv32_exec_pkg::xlen-1:0]     rs1_data,
    input  logic [rv32_exec_pkg::xlen-1:0]     rs2_data,
    output logic                               wb_valid,
    output logic [4:0]                         wb_rd,
    output logic [rv32_exec_pkg::xlen-1:0]     wb_data,
    output logic                               wb_we,
    output logic                               illegal_instr
);
    import rv32_exec_pkg::*;

    logic             dec_valid;
    alu_op_e          dec_op;
    logic [xlen-1:0]  dec_operand_a;
    logic [xlen-1:0]  dec_operand_b;
    logic [4:0]       dec_rd;
    logic             dec_illegal;
    logic [xlen-1:0]  alu_result;

    instr_decoder u_decode (                   // Stage 1 register
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b),
        .dec_rd        (dec_rd),
        .dec_illegal   (dec_illegal)
    );

    arithmetic_logic_unit u_execute (          // Between the two registers
        .op        (dec_op),
        .operand_a (dec_operand_a),
        .operand_b (dec_operand_b),
        .result    (alu_result)
    );

    writeback_stage u_result (                 // Stage 2 register
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_rd        (dec_rd),
        .dec_illegal   (dec_illegal),
        .alu_result    (alu_result),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .wb_we         (wb_we),
        .illegal_instr (illegal_instr)
    );

endmodule

// File: design/writeback_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writes to x0 are dropped; illegal results read back as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module writeback_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dec_valid,
    input  logic [4:0]                         dec_rd,
    input  logic                               dec_illegal,
    input  logic [rv32_exec_pkg::xlen-1:0]     alu_result,
    output logic                               wb_valid,      // One pulse per instruction
    output logic [4:0]                         wb_rd,
    output logic [rv32_exec_pkg::xlen-1:0]     wb_data,
    output logic                               wb_we,         // Register file write
    output logic                               illegal_instr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid      <= 1'b0;
            wb_we         <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            wb_valid      <= dec_valid;
            wb_we         <= dec_valid && !dec_illegal && (dec_rd != 5'd0);
            illegal_instr <= dec_valid && dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            wb_rd   <= dec_rd;
            wb_data <= dec_illegal ? '0 : alu_result;  // Illegal result masked
        end
    end

    a_we_has_valid: assert property (@(posedge clk) disable iff (reset)
        wb_we |-> wb_valid);

    a_we_not_x0: assert property (@(posedge clk) disable iff (reset)
        wb_we |-> (wb_rd != 5'd0));

    // A trapped instruction never reaches the register file
    a_we_not_illegal: assert property (@(posedge clk) disable iff (reset)
        !(wb_we && illegal_instr));

endmodule

// File: decode/instr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Payload latched only on issue_valid; outputs hold while idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decoder (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               issue_valid,  // One strobe per instruction
    input  rv32_exec_pkg::instr_u              instr,
    input  logic [rv32_exec_pkg::xlen-1:0]     pc,
    input  logic [rv32_exec_pkg::xlen-1:0]     rs1_data,
    input  logic [rv32_exec_pkg::xlen-1:0]     rs2_data,
    output logic                               dec_valid,
    output rv32_exec_pkg::alu_op_e             dec_op,
    output logic [rv32_exec_pkg::xlen-1:0]     dec_operand_a,
    output logic [rv32_exec_pkg::xlen-1:0]     dec_operand_b,
    output logic [4:0]                         dec_rd,
    output logic                               dec_illegal
);
    import rv32_exec_pkg::*;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;   // SUB, SRA, SRAI

    alu_op_e          op_nxt;
    logic             use_pc;                          // Operand A from pc
    logic [xlen-1:0]  operand_b_nxt;
    logic [4:0]       rd_nxt;
    logic             illegal_nxt;
    logic             f7_base;
    logic             f7_alt;
    logic [xlen-1:0]  imm_i;
    logic [xlen-1:0]  imm_u;
    logic [xlen-1:0]  shamt;

    assign f7_base = (instr.r.funct7 == funct7_base);  // Same bits as imm[11:5]
    assign f7_alt  = (instr.r.funct7 == funct7_alt);
    assign imm_i   = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm}; // Sign extended
    assign imm_u   = {instr.u.imm, 12'b0};
    assign shamt   = {{(xlen-5){1'b0}}, instr.r.rs2};  // Shift amount field

    always_comb begin
        op_nxt        = alu_add;
        use_pc        = 1'b0;
        operand_b_nxt = rs2_data;
        rd_nxt        = instr.r.rd;                    // Same field in every format
        illegal_nxt   = 1'b0;
        case (instr.r.opcode)
            opc_op: begin
                case (instr.r.funct3)
                    3'b000:  op_nxt = f7_alt ? alu_sub : alu_add;
                    3'b001:  op_nxt = alu_sll;
                    3'b010:  op_nxt = alu_slt;
                    3'b011:  op_nxt = alu_sltu;
                    3'b100:  op_nxt = alu_xor;
                    3'b101:  op_nxt = f7_alt ? alu_sra : alu_srl;
                    3'b110:  op_nxt = alu_or;
                    default: op_nxt = alu_and;
                endcase
                // Alternate funct7 only valid for SUB and SRA
                illegal_nxt = !(f7_base || (f7_alt &&
                              (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101)));
            end
            opc_op_imm: begin
                operand_b_nxt = imm_i;
                case (instr.i.funct3)
                    3'b000:  op_nxt = alu_add;
                    3'b001: begin
                        op_nxt        = alu_sll;
                        operand_b_nxt = shamt;
                        illegal_nxt   = !f7_base;  // SLLI needs zero upper bits
                    end
                    3'b010:  op_nxt = alu_slt;
                    3'b011:  op_nxt = alu_sltu;
                    3'b100:  op_nxt = alu_xor;
                    3'b101: begin
                        op_nxt        = f7_alt ? alu_sra : alu_srl;
                        operand_b_nxt = shamt;
                        illegal_nxt   = !(f7_base || f7_alt);
                    end
                    3'b110:  op_nxt = alu_or;
                    default: op_nxt = alu_and;
                endcase
            end
            opc_jal: begin
                use_pc        = 1'b1;
                operand_b_nxt = xlen'(4);         // Link value pc + 4
            end
            opc_jalr: begin
                use_pc        = 1'b1;
                operand_b_nxt = xlen'(4);
                illegal_nxt   = (instr.i.funct3 != 3'b000);
            end
            opc_auipc: begin
                use_pc        = 1'b1;
                operand_b_nxt = imm_u;
            end
            default: illegal_nxt = 1'b1;          // Unsupported opcode
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin                    // Hold payload between issues
            dec_op        <= op_nxt;
            dec_operand_a <= use_pc ? pc : rs1_data;
            dec_operand_b <= operand_b_nxt;
            dec_rd        <= rd_nxt;
            dec_illegal   <= illegal_nxt;
        end
    end

    // Payload captured with a valid issue is always fully known
    a_dec_op_known: assert property (@(posedge clk) disable iff (reset)
        dec_valid |-> !$isunknown(dec_op));

endmodule

// File: execute/arithmetic_logic_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational; shifts use operand_b[4:0] only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arithmetic_logic_unit (
    input  rv32_exec_pkg::alu_op_e             op,          // Decoded operation
    input  logic [rv32_exec_pkg::xlen-1:0]     operand_a,   // rs1 or pc
    input  logic [rv32_exec_pkg::xlen-1:0]     operand_b,   // rs2, immediate or 4
    output logic [rv32_exec_pkg::xlen-1:0]     result
);
    import rv32_exec_pkg::*;

    logic [4:0]  shift_amount;
    logic        less_signed;
    logic        less_unsigned;

    assign shift_amount  = operand_b[4:0];                      // RV32 shift range
    assign less_signed   = $signed(operand_a) < $signed(operand_b);
    assign less_unsigned = operand_a < operand_b;

    always_comb begin
        case (op)
            alu_add: begin
                result = operand_a + operand_b;        // ADD, ADDI, links, AUIPC
            end
            alu_sub: begin
                result = operand_a - operand_b;
            end
            alu_sll: begin
                result = operand_a << shift_amount;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, less_signed};   // 1 or 0
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, less_unsigned};
            end
            alu_xor: begin
                result = operand_a ^ operand_b;
            end
            alu_srl: begin
                result = operand_a >> shift_amount;    // Zero fill
            end
            alu_sra: begin
                result = $unsigned($signed(operand_a) >>> shift_amount); // Sign fill
            end
            alu_or: begin
                result = operand_a | operand_b;
            end
            alu_and: begin
                result = operand_a & operand_b;
            end
            default: begin
                result = '0;                           // Unused encodings
            end
        endcase
    end

endmodule

// File: common/rv32_exec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I only; no M/F extensions. LUI, loads, stores, branches absent
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv32_exec_pkg;

    localparam int xlen = 32;                   // Data path width

    // Major opcodes handled by the execute slice
    localparam logic [6:0] opc_op     = 7'b0110011; // R-type ALU
    localparam logic [6:0] opc_op_imm = 7'b0010011; // I-type ALU
    localparam logic [6:0] opc_jal    = 7'b1101111; // Jump and link
    localparam logic [6:0] opc_jalr   = 7'b1100111; // Jump and link register
    localparam logic [6:0] opc_auipc  = 7'b0010111; // Add upper immediate to pc

    typedef enum logic [3:0] {
        alu_add,                                // Also jumps and AUIPC
        alu_sub,
        alu_sll,
        alu_slt,                                // Signed compare
        alu_sltu,                               // Unsigned compare
        alu_xor,
        alu_srl,
        alu_sra,                                // Arithmetic right shift
        alu_or,
        alu_and
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;                        // Also shamt for I shifts
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;                       // Sign bit is imm[11]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic        imm_20;                    // Offset sign
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_j_t;

    typedef struct packed {
        logic [19:0] imm;                       // Upper 20 bits of result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    // One instruction word, four format views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
        instr_u_t u;
    } instr_u;

endpackage
